/* design/board_pkg.sv */
// Panel geometry assumes an 800x480 touch panel with coordinates already scaled to pixels
`default_nettype none

package board_pkg;

	//========================================
	// Touch panel geometry
	//========================================
	localparam int COORD_W  = 12;                  // Bits per decoded coordinate
	typedef logic [COORD_W-1:0] coord_t;

	localparam int PANEL_W  = 800;                 // Visible pixels across
	localparam int PANEL_H  = 480;                 // Visible lines down
	localparam int BUTTON_Y = 400;                 // Colour strip starts here
	localparam int REGION_W = 100;                 // One button or one guess column

	//========================================
	// Seven-segment digits
	//========================================
	localparam int SEG_W      = 7;                 // Segments g..a, no decimal point
	typedef logic [SEG_W-1:0] seg_t;               // Active low

	localparam int NUM_DIGITS = 8;
	localparam logic [NUM_DIGITS-1:0] BLANK_MASK = 8'b1000_1000; // Digits 3 and 7 stay dark

endpackage

`default_nettype wire

/* design/game_pkg.sv */
// Game rules are fixed at four columns and eight colours; row count is a top level parameter
`default_nettype none

package game_pkg;

	//========================================
	// Code and colours
	//========================================
	localparam int NUM_COLS    = 4;                // Pegs per row
	localparam int COLOUR_W    = 3;
	localparam int NUM_COLOURS = 8;

	typedef enum logic [COLOUR_W-1:0] {
		COL_RED     = 3'd0,
		COL_GREEN   = 3'd1,
		COL_BLUE    = 3'd2,
		COL_YELLOW  = 3'd3,
		COL_CYAN    = 3'd4,
		COL_MAGENTA = 3'd5,
		COL_WHITE   = 3'd6,
		COL_ORANGE  = 3'd7
	} colour_e;

	typedef logic [NUM_COLS-1:0][COLOUR_W-1:0] code_t; // Column 0 in bits 2..0

	typedef logic [2:0] peg_t;                     // Holds 0 to 4

	//========================================
	// Rows, commands and states
	//========================================
	localparam int NUM_ROWS_DEF = 8;
	typedef logic [2:0] row_t;

	typedef enum logic [1:0] {
		OP_COLOUR = 2'd0,                          // Pick current colour
		OP_PLACE  = 2'd1,                          // Drop it into a column
		OP_SUBMIT = 2'd2,                          // Score row or start or end game
		OP_CLEAR  = 2'd3                           // Wipe the guess row
	} op_e;

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_PLAY  = 3'd1,
		ST_SCORE = 3'd2,
		ST_WON   = 3'd3,
		ST_LOST  = 3'd4
	} state_e;

endpackage

`default_nettype wire

/* design/game_cmd_if.sv */
// Command strobe has no back-pressure so every valid cycle is one command
`timescale 1ns/1ps
`default_nettype none

interface game_cmd_if;
	import game_pkg::*;

	logic    valid;                                // Single cycle strobe
	op_e     op;
	logic [1:0] column;                            // Guess column for OP_PLACE
	colour_e colour;                               // Colour for OP_COLOUR

	modport decoder
	(
		output valid,
		output op,
		output column,
		output colour
	);

	modport controller
	(
		input valid,
		input op,
		input column,
		input colour
	);

endinterface

`default_nettype wire

/* design/reset_delay.sv */
// Reset must be asserted for at least one clock; core_reset releases RESET_HOLD cycles later
`timescale 1ns/1ps
`default_nettype none

module reset_delay
#(
	parameter int RESET_HOLD = 16
)
(
	input  wire  iCLK_50,
	input  wire  reset,
	output logic core_reset
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic [CNT_W-1:0] cnt_q;                       // Cycles since reset fell

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
			cnt_q <= '0;                           // Restart the hold window
		else if (cnt_q != CNT_W'(RESET_HOLD))
			cnt_q <= cnt_q + 1'b1;                 // Saturates at the hold count
	end

	assign core_reset = reset || (cnt_q != CNT_W'(RESET_HOLD)); // Held until count done

	// Core stays in reset through the whole hold window after any reset cycle
	a_hold_window: assert property (@(posedge iCLK_50)
		reset |-> core_reset [*RESET_HOLD+1]);

endmodule

`default_nettype wire

/* design/touch_decoder.sv */
// Touches off the panel are dropped; regions assume the 800x480 layout in board_pkg
`timescale 1ns/1ps
`default_nettype none

module touch_decoder
(
	input  wire               iCLK_50,
	input  wire               reset,
	input  board_pkg::coord_t x_coord,
	input  board_pkg::coord_t y_coord,
	input  wire               new_coord,
	game_cmd_if.decoder       cmd
);
	import board_pkg::*;
	import game_pkg::*;

	localparam int CLEAR_X  = 4 * REGION_W;        // Clear button left edge
	localparam int SUBMIT_X = 6 * REGION_W;        // Submit button left edge

	coord_t region;                                // Button or column index
	logic   hit;                                   // Touch lands on the panel
	op_e    op_d;

	assign region = x_coord / coord_t'(REGION_W);

	//========================================
	// Screen region to command
	//========================================
	always_comb
	begin
		hit  = 1'b1;
		op_d = OP_SUBMIT;
		if ((x_coord >= coord_t'(PANEL_W)) || (y_coord >= coord_t'(PANEL_H)))
			hit = 1'b0;                            // Off the glass
		else if (y_coord >= coord_t'(BUTTON_Y))
			op_d = OP_COLOUR;                      // Bottom colour strip
		else if (x_coord < coord_t'(CLEAR_X))
			op_d = OP_PLACE;                       // Guess columns 0..3
		else if (x_coord < coord_t'(SUBMIT_X))
			op_d = OP_CLEAR;
		else
			op_d = OP_SUBMIT;
	end

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
			cmd.valid <= 1'b0;
		else
			cmd.valid <= new_coord && hit;         // One strobe per touch
	end

	always_ff @(posedge iCLK_50)
	begin
		if (new_coord)
		begin
			cmd.op     <= op_d;
			cmd.column <= region[1:0];
			cmd.colour <= colour_e'(region[COLOUR_W-1:0]);
		end
	end

	// A command never appears without a touch the cycle before
	a_valid_follows_touch: assert property (@(posedge iCLK_50) disable iff (reset)
		cmd.valid |-> $past(new_coord));

endmodule

`default_nettype wire

/* design/peg_scorer.sv */
// Result holds until the next start; one start per cycle is accepted with fixed 2 cycle latency
`timescale 1ns/1ps
`default_nettype none

module peg_scorer
(
	input  wire              iCLK_50,
	input  wire              reset,
	input  wire              start,
	input  game_pkg::code_t  guess,
	input  game_pkg::code_t  secret,
	output logic             done,
	output game_pkg::peg_t   black,
	output game_pkg::peg_t   white
);
	import game_pkg::*;

	logic [NUM_COLS-1:0]    match_d, match_q;  // Right colour, right column
	peg_t [NUM_COLOURS-1:0] gcnt_d, gcnt_q;    // Colour histogram of guess
	peg_t [NUM_COLOURS-1:0] scnt_d, scnt_q;    // Colour histogram of secret
	logic                   v1_q;
	peg_t                   black_d, common_d, white_d;

	//========================================
	// Stage 1 matches and histograms
	//========================================
	always_comb
	begin
		for (int i = 0; i < NUM_COLS; i++)
			match_d[i] = (guess[i] == secret[i]);
		for (int c = 0; c < NUM_COLOURS; c++)
		begin
			gcnt_d[c] = '0;
			scnt_d[c] = '0;
			for (int i = 0; i < NUM_COLS; i++)
			begin
				if (guess[i] == COLOUR_W'(c))
					gcnt_d[c] = gcnt_d[c] + 1'b1;
				if (secret[i] == COLOUR_W'(c))
					scnt_d[c] = scnt_d[c] + 1'b1;
			end
		end
	end

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
			v1_q <= 1'b0;
		else
			v1_q <= start;
		match_q <= match_d;                        // Payload flows every cycle
		gcnt_q  <= gcnt_d;
		scnt_q  <= scnt_d;
	end

	//========================================
	// Stage 2 peg counts
	//========================================
	always_comb
	begin
		black_d  = '0;
		common_d = '0;
		for (int i = 0; i < NUM_COLS; i++)
			black_d = black_d + peg_t'(match_q[i]);
		for (int c = 0; c < NUM_COLOURS; c++)
			common_d = common_d + ((gcnt_q[c] < scnt_q[c]) ? gcnt_q[c] : scnt_q[c]);
		white_d = common_d - black_d;              // Exact hits counted once only
	end

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			done  <= 1'b0;
			black <= '0;
			white <= '0;
		end
		else
		begin
			done <= v1_q;
			if (v1_q)
			begin
				black <= black_d;                  // Kept for display between rows
				white <= white_d;
			end
		end
	end

	// Histogram overlap can never produce more pegs than columns
	a_peg_total: assert property (@(posedge iCLK_50) disable iff (reset)
		done |-> ((4'(black) + 4'(white)) <= 4'(NUM_COLS)));

endmodule

`default_nettype wire

/* design/game_controller.sv */
// Commands outside the accepting state are dropped; win and loss flags show with score_valid
`timescale 1ns/1ps
`default_nettype none

module game_controller
#(
	parameter int NUM_ROWS = game_pkg::NUM_ROWS_DEF
)
(
	input  wire              iCLK_50,
	input  wire              reset,
	game_cmd_if.controller   cmd,
	input  game_pkg::code_t  secret_in,
	output game_pkg::code_t  guess,
	output game_pkg::row_t   row_count,
	output game_pkg::peg_t   black_pegs,
	output game_pkg::peg_t   white_pegs,
	output logic             score_valid,
	output logic             game_won,
	output logic             game_lost
);
	import game_pkg::*;

	state_e  state_q;
	code_t   guess_q;
	code_t   secret_q;                             // Loaded at game start
	row_t    row_q;
	colour_e cur_colour_q;                         // Last colour picked
	logic    start_q;                              // Scorer kick
	logic    sc_done;
	peg_t    sc_black, sc_white;
	logic    submit;
	logic    win_now;
	logic    last_row;

	assign submit   = cmd.valid && (cmd.op == OP_SUBMIT);
	assign win_now  = (sc_black == peg_t'(NUM_COLS));
	assign last_row = (row_q == row_t'(NUM_ROWS - 1));

	//========================================
	// Game FSM
	//========================================
	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			state_q      <= ST_IDLE;
			guess_q      <= '0;
			row_q        <= '0;
			cur_colour_q <= COL_RED;
			start_q      <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;                       // Strobe by default
			case (state_q)
				ST_IDLE:
					if (submit)
					begin
						guess_q <= '0;             // Fresh board
						row_q   <= '0;
						state_q <= ST_PLAY;
					end
				ST_PLAY:
					if (cmd.valid)
					begin
						case (cmd.op)
							OP_COLOUR: cur_colour_q <= cmd.colour;
							OP_PLACE:  guess_q[cmd.column] <= cur_colour_q;
							OP_CLEAR:  guess_q <= '0;
							OP_SUBMIT:
							begin
								start_q <= 1'b1;   // Score this row
								state_q <= ST_SCORE;
							end
						endcase
					end
				ST_SCORE:
					if (sc_done)
					begin
						if (win_now)
							state_q <= ST_WON;
						else if (last_row)
							state_q <= ST_LOST;    // Row count stays on last row
						else
						begin
							row_q   <= row_q + 1'b1;
							state_q <= ST_PLAY;
						end
					end
				ST_WON, ST_LOST:
					if (submit)
						state_q <= ST_IDLE;        // Acknowledge result
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLK_50)
	begin
		if ((state_q == ST_IDLE) && submit)
			secret_q <= secret_in;                 // Switches sampled once per game
	end

	peg_scorer i_peg_scorer
	(
		.iCLK_50 (iCLK_50),
		.reset   (reset),
		.start   (start_q),
		.guess   (guess_q),
		.secret  (secret_q),
		.done    (sc_done),
		.black   (sc_black),
		.white   (sc_white)
	);

	//========================================
	// Outputs
	//========================================
	assign guess       = guess_q;
	assign row_count   = row_q;
	assign black_pegs  = sc_black;                 // Scorer holds last result
	assign white_pegs  = sc_white;
	assign score_valid = sc_done;
	assign game_won    = (state_q == ST_WON) || (sc_done && win_now);
	assign game_lost   = (state_q == ST_LOST) || (sc_done && !win_now && last_row);

	// Row index never passes the last row of the board
	a_row_in_range: assert property (@(posedge iCLK_50) disable iff (reset)
		int'(row_q) < NUM_ROWS);

endmodule

`default_nettype wire

/* design/seg7_display.sv */
// Shows only the low 12 bits of each coordinate; segment outputs are active low
`timescale 1ns/1ps
`default_nettype none

module seg7_display
(
	input  wire                                          iCLK_50,
	input  wire                                          reset,
	input  board_pkg::coord_t                            x_coord,
	input  board_pkg::coord_t                            y_coord,
	input  wire                                          new_coord,
	output board_pkg::seg_t [board_pkg::NUM_DIGITS-1:0] hex
);
	import board_pkg::*;

	coord_t x_q, y_q;                              // Last touch
	logic [NUM_DIGITS-1:0][3:0] nib;               // One nibble per digit

	// Hex digit to segments g..a
	function automatic seg_t hex_to_seg(input logic [3:0] val);
		case (val)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;            // F
		endcase
	endfunction

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			x_q <= '0;                             // Display reads 000 000
			y_q <= '0;
		end
		else if (new_coord)
		begin
			x_q <= x_coord;
			y_q <= y_coord;
		end
	end

	assign nib = {4'h0, x_q, 4'h0, y_q};           // x on the left half

	//========================================
	// Digit drivers
	//========================================
	for (genvar d = 0; d < NUM_DIGITS; d++)
	begin : g_digit
		assign hex[d] = BLANK_MASK[d] ? {SEG_W{1'b1}} : hex_to_seg(nib[d]);
	end

endmodule

`default_nettype wire

/* design/mastermind_top.sv */
// Touch coordinates arrive decoded; only sw bits 11..0 are used as the secret code
`timescale 1ns/1ps
`default_nettype none

module mastermind_top
#(
	parameter int NUM_ROWS = game_pkg::NUM_ROWS_DEF
)
(
	input  wire                                          iCLK_50,
	input  wire                                          reset,
	input  wire [17:0]                                   sw,
	input  board_pkg::coord_t                            x_coord,
	input  board_pkg::coord_t                            y_coord,
	input  wire                                          new_coord,
	output board_pkg::seg_t [board_pkg::NUM_DIGITS-1:0] hex,
	output game_pkg::code_t                              guess,
	output game_pkg::row_t                               row_count,
	output game_pkg::peg_t                               black_pegs,
	output game_pkg::peg_t                               white_pegs,
	output logic                                         score_valid,
	output logic                                         game_won,
	output logic                                         game_lost
);

	logic core_reset;                              // Stretched board reset

	game_cmd_if cmd_if ();                         // Decoder to controller

	reset_delay
	#(
		.RESET_HOLD (16)
	)
	i_reset_delay
	(
		.iCLK_50    (iCLK_50),
		.reset      (reset),
		.core_reset (core_reset)
	);

	touch_decoder i_touch_decoder
	(
		.iCLK_50   (iCLK_50),
		.reset     (core_reset),
		.x_coord   (x_coord),
		.y_coord   (y_coord),
		.new_coord (new_coord),
		.cmd       (cmd_if.decoder)
	);

	game_controller
	#(
		.NUM_ROWS (NUM_ROWS)
	)
	i_game_controller
	(
		.iCLK_50     (iCLK_50),
		.reset       (core_reset),
		.cmd         (cmd_if.controller),
		.secret_in   (sw[11:0]),                   // Secret code switches
		.guess       (guess),
		.row_count   (row_count),
		.black_pegs  (black_pegs),
		.white_pegs  (white_pegs),
		.score_valid (score_valid),
		.game_won    (game_won),
		.game_lost   (game_lost)
	);

	seg7_display i_seg7_display
	(
		.iCLK_50   (iCLK_50),
		.reset     (core_reset),
		.x_coord   (x_coord),
		.y_coord   (y_coord),
		.new_coord (new_coord),
		.hex       (hex)
	);

endmodule

`default_nettype wire

/* testbench/tb_mastermind.sv */
// Expects RESET_HOLD of 16 in the top level and an 800x480 panel; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_mastermind;
	import board_pkg::*;
	import game_pkg::*;

	localparam int NUM_ROWS   = NUM_ROWS_DEF;
	localparam int RESET_HOLD = 16;
	localparam int SCORE_LAT  = 4;                 // Falling edges from submit drive to score_valid
	localparam int SCORE_WAIT = 12;                // Give up on score_valid after this
	localparam int MAX_CYCLES = 4000;              // Tests need well under 1000 cycles

	logic                  iCLK_50;
	logic                  reset;
	logic [17:0]           sw;
	coord_t                x_coord, y_coord;
	logic                  new_coord;
	seg_t [NUM_DIGITS-1:0] hex;
	code_t                 guess;
	row_t                  row_count;
	peg_t                  black_pegs, white_pegs;
	logic                  score_valid, game_won, game_lost;
	int                    cycle_cnt = 0;
	code_t                 secret;                 // Code of the running game
	row_t                  exp_row;                // Rows scored so far in this game

	mastermind_top #(.NUM_ROWS(NUM_ROWS)) i_mastermind_top
	(
		.iCLK_50     (iCLK_50),
		.reset       (reset),
		.sw          (sw),
		.x_coord     (x_coord),
		.y_coord     (y_coord),
		.new_coord   (new_coord),
		.hex         (hex),
		.guess       (guess),
		.row_count   (row_count),
		.black_pegs  (black_pegs),
		.white_pegs  (white_pegs),
		.score_valid (score_valid),
		.game_won    (game_won),
		.game_lost   (game_lost)
	);

	always #5 iCLK_50 = ~iCLK_50;                  // 100 MHz sim clock

	always @(posedge iCLK_50)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			stop_run($sformatf("Timeout: the run went past %0d clock cycles", MAX_CYCLES));
	end

	//========================================
	// Error reporting and compares
	//========================================
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_peg(input peg_t got, input peg_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_code(input code_t got, input code_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_row(input row_t got, input row_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_seg(input seg_t got, input seg_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	//========================================
	// Reference models
	//========================================
	function automatic seg_t seg_for_nibble(input logic [3:0] n);
		case (n)                                   // Active low with segment a in bit 0
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// Classic peg pairing with exact hits first
	task automatic model_score(input code_t g, input code_t s, output peg_t b, output peg_t w);
		bit used_g [NUM_COLS];
		bit used_s [NUM_COLS];
		bit found;
		b = 0;
		w = 0;
		for (int i = 0; i < NUM_COLS; i++)
		begin
			used_g[i] = (g[i] == s[i]);
			used_s[i] = used_g[i];
			b = b + peg_t'(used_g[i]);
		end
		for (int i = 0; i < NUM_COLS; i++)
		begin
			found = used_g[i];
			for (int j = 0; j < NUM_COLS; j++)
			begin
				if (!found && !used_s[j] && (g[i] == s[j]))
				begin
					used_s[j] = 1'b1;              // Each secret peg pairs once
					found     = 1'b1;
					w         = w + 1'b1;
				end
			end
		end
	endtask

	//========================================
	// Stimulus helpers
	//========================================
	task automatic touch(input int x, input int y);
		@(negedge iCLK_50);
		x_coord   = coord_t'(x);
		y_coord   = coord_t'(y);
		new_coord = 1'b1;
		@(negedge iCLK_50);
		new_coord = 1'b0;                          // One cycle strobe
	endtask

	task automatic touch_submit();
		touch(600 + $urandom % 200, $urandom % 400);
	endtask

	task automatic check_display(input coord_t x, input coord_t y);
		seg_t exp;
		for (int d = 0; d < NUM_DIGITS; d++)
		begin
			if ((d == 3) || (d == 7))
				exp = 7'h7F;                       // Blanked digit
			else if (d < 3)
				exp = seg_for_nibble(y[4*d +: 4]);
			else
				exp = seg_for_nibble(x[4*(d-4) +: 4]);
			check_seg(hex[d], exp, $sformatf("digit %0d", d));
		end
	endtask

	task automatic enter_guess(input code_t g);
		for (int i = 0; i < NUM_COLS; i++)
		begin
			touch(int'(g[i]) * 100 + $urandom % 100, 400 + $urandom % 80); // Colour strip
			touch(i * 100 + $urandom % 100, $urandom % 400);               // Guess column
		end
		@(negedge iCLK_50);
		check_code(guess, g, "guess after entry");
	endtask

	task automatic start_game();
		secret  = code_t'($urandom);
		sw      = {6'($urandom), secret};          // Upper switches unused
		exp_row = '0;
		touch_submit();
		@(negedge iCLK_50);
		check_code(guess, '0, "guess at game start");
		check_row(row_count, exp_row, "row_count at game start");
		check_flag(game_won, 1'b0, "game_won at game start");
		check_flag(game_lost, 1'b0, "game_lost at game start");
	endtask

	task automatic score_guess(input code_t g);
		peg_t b, w;
		bit   last;
		int   n;
		model_score(g, secret, b, w);
		last = (int'(exp_row) == NUM_ROWS - 1);
		@(negedge iCLK_50);
		x_coord   = coord_t'(600 + $urandom % 200);
		y_coord   = coord_t'($urandom % 400);
		new_coord = 1'b1;
		n = 0;
		while ((n == 0) || (!score_valid && (n < SCORE_WAIT)))
		begin
			@(negedge iCLK_50);
			n++;
			if (n == 1)
				new_coord = 1'b0;
		end
		if (!score_valid)
			stop_run("score_valid never rose after the submit touch");
		if (n != SCORE_LAT)
			stop_run($sformatf("Fail at %0t: score_valid after %0d cycles, expected %0d",
				$time, n, SCORE_LAT));
		check_peg(black_pegs, b, "black_pegs");
		check_peg(white_pegs, w, "white_pegs");
		check_flag(game_won, b == 3'd4, "game_won with score");
		check_flag(game_lost, (b != 3'd4) && last, "game_lost with score");
		@(negedge iCLK_50);
		check_flag(score_valid, 1'b0, "score_valid one cycle later");
		if ((b == 3'd4) || last)
			check_row(row_count, exp_row, "row_count after last score");
		else
		begin
			exp_row = exp_row + 1'b1;              // Next row of the board
			check_row(row_count, exp_row, "row_count after score");
		end
	endtask

	function automatic code_t wrong_guess();
		code_t g;
		g = code_t'($urandom);
		while (g == secret)
			g = code_t'($urandom);                 // Never the winning code
		return g;
	endfunction

	//========================================
	// Directed tests
	//========================================
	task automatic reset_dut();
		reset = 1'b1;
		repeat (8) @(negedge iCLK_50);
		reset = 1'b0;
		repeat (RESET_HOLD + 1) @(negedge iCLK_50); // Core reset hold window
	endtask

	task automatic test_after_reset();
		check_flag(score_valid, 1'b0, "score_valid after reset");
		check_flag(game_won, 1'b0, "game_won after reset");
		check_flag(game_lost, 1'b0, "game_lost after reset");
		check_row(row_count, '0, "row_count after reset");
		check_code(guess, '0, "guess after reset");
		check_display('0, '0);
	endtask

	task automatic test_display();
		int x, y;
		touch(12'h18F, 12'h1DF);                   // Colour strip pick while idle
		check_display(12'h18F, 12'h1DF);
		touch(12'h123, 12'h0AB);                   // Place touch that idle ignores
		check_display(12'h123, 12'h0AB);
		touch(12'hFED, 12'hCBA);                   // Off the panel
		check_display(12'hFED, 12'hCBA);
		for (int k = 0; k < 6; k++)
		begin
			x = 800 + $urandom % 3296;
			y = $urandom % 4096;
			touch(x, y);
			check_display(coord_t'(x), coord_t'(y));
		end
		check_code(guess, '0, "guess after idle touches");
	endtask

	task automatic test_guess_entry();
		start_game();
		enter_guess(code_t'($urandom));
		touch(400 + $urandom % 200, $urandom % 400); // Clear button
		@(negedge iCLK_50);
		check_code(guess, '0, "guess after clear");
	endtask

	task automatic test_random_guesses(input int count);
		code_t g;
		for (int k = 0; k < count; k++)
		begin
			g = wrong_guess();
			enter_guess(g);
			score_guess(g);
		end
	endtask

	task automatic test_win();
		enter_guess(secret);
		score_guess(secret);
		check_peg(black_pegs, 3'd4, "black_pegs for the secret");
		check_peg(white_pegs, 3'd0, "white_pegs for the secret");
		touch_submit();                            // Back to idle
		@(negedge iCLK_50);
		check_flag(game_won, 1'b0, "game_won after leaving the game");
	endtask

	task automatic test_loss();
		code_t g;
		start_game();
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			g = wrong_guess();
			enter_guess(g);
			score_guess(g);
		end
		check_flag(game_lost, 1'b1, "game_lost after the last row");
	endtask

	initial
	begin
		void'($urandom(32'h49e7fbab));
		iCLK_50   = 1'b0;
		reset     = 1'b1;
		sw        = '0;
		x_coord   = '0;
		y_coord   = '0;
		new_coord = 1'b0;
		reset_dut();
		test_after_reset();
		test_display();
		test_guess_entry();
		test_random_guesses(4);
		test_win();
		test_loss();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/board_pkg.sv
design/game_pkg.sv
design/game_cmd_if.sv
design/reset_delay.sv
design/touch_decoder.sv
design/peg_scorer.sv
design/game_controller.sv
design/seg7_display.sv
design/mastermind_top.sv
testbench/tb_mastermind.sv
